// File: arcade_shell.f
+incdir+source
+incdir+test
source/arcade_shell_pkg.sv
source/spi_user_io.sv
source/control_regs.sv
source/control_mapper.sv
source/sigma_delta_dac.sv
source/arcade_shell.sv
test/tb_arcade_shell.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_arcade_shell \
	-f arcade_shell.f -o tb_arcade_shell

out=$(./obj_dir/tb_arcade_shell) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^Simulation finished: PASS$'; then
	exit 0
fi
exit 1

// File: source/arcade_shell.sv
// Board shell top; no PLL inside, so clk_sys must come in already locked and rst_n held until it is.
`timescale 1ns/1ps
`default_nettype none
`include "arcade_shell_config.svh"

module arcade_shell (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire                          spi_sck,
	input  wire                          spi_ss_io,
	input  wire                          spi_mosi,
	input  wire [`DAC_BITS-1:0]          audio_in,
	output wire                          spi_miso,
	output wire                          audio_out,
	output wire                          core_reset,
	output wire                          coin,
	output wire arcade_shell_pkg::player_ctrl_t player1,
	output wire arcade_shell_pkg::player_ctrl_t player2,
	output wire [1:0]                    scanlines,
	output wire                          blend
);

	import arcade_shell_pkg::*;

	axil_req_t  axil_req;
	axil_rsp_t  axil_rsp;
	shell_cfg_t cfg;

	spi_user_io u_spi_user_io (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.spi_sck   (spi_sck),
		.spi_ss_io (spi_ss_io),
		.spi_mosi  (spi_mosi),
		.axil_rsp  (axil_rsp),
		.spi_miso  (spi_miso),
		.axil_req  (axil_req)
	);

	control_regs u_control_regs (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.cfg      (cfg)
	);

	control_mapper u_control_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.player1    (player1),
		.player2    (player2),
		.coin       (coin),
		.core_reset (core_reset)
	);

	sigma_delta_dac #(
		.C_BITS (`DAC_BITS)
	) u_sigma_delta_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.dac_in  (audio_in),
		.dac_out (audio_out)
	);

	// Video options go straight to the scan doubler outside this shell.
	assign scanlines = cfg.status[4:3];
	assign blend     = cfg.status[5];

endmodule

`default_nettype wire

// File: source/arcade_shell_config.svh
// Build constants; the SPI command codes must match the host firmware and CORE_ID is fixed at build.
`ifndef ARCADE_SHELL_CONFIG_SVH
`define ARCADE_SHELL_CONFIG_SVH

// Read-only tag returned at reg_core_id.
`define CORE_ID 32'h5048_4e58

// The cabinet monitor is mounted rotated.
`define ORIENT_ROT 1'b1

// Width of the game audio sample.
`define DAC_BITS 12

// Host command bytes.
`define SPI_CMD_WR 8'h15
`define SPI_CMD_RD 8'h16

`endif

// File: source/arcade_shell_pkg.sv
// Shared bus and control types; addresses are byte offsets on an 8-bit AXI4-Lite space.
`default_nettype none

package arcade_shell_pkg;

	// Master-to-slave half of the AXI4-Lite link.
	typedef struct packed {
		logic        awvalid;
		logic [7:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        bready;
		logic        arvalid;
		logic [7:0]  araddr;
		logic        rready;
	} axil_req_t;

	// Slave-to-master half of the AXI4-Lite link.
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	localparam logic [1:0] axil_okay   = 2'b00;
	localparam logic [1:0] axil_slverr = 2'b10;

	localparam logic [7:0] reg_status  = 8'h00;
	localparam logic [7:0] reg_joy0    = 8'h04;
	localparam logic [7:0] reg_joy1    = 8'h08;
	localparam logic [7:0] reg_buttons = 8'h0C;
	localparam logic [7:0] reg_core_id = 8'h10;

	// Bit positions inside a joystick word.
	localparam int joy_right   = 0;
	localparam int joy_left    = 1;
	localparam int joy_down    = 2;
	localparam int joy_up      = 3;
	localparam int joy_fire    = 4;
	localparam int joy_barrier = 5;
	localparam int joy_start   = 6;
	localparam int joy_coin    = 7;

	typedef struct packed {
		logic [31:0] status;
		logic [7:0]  joy0;
		logic [7:0]  joy1;
		logic [3:0]  buttons;
	} shell_cfg_t;

	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
		logic fire;
		logic barrier;
		logic start;
	} player_ctrl_t;

endpackage

`default_nettype wire

// File: source/control_mapper.sv
// Registered player control mapping; rotation is status bit 2 XOR the cabinet's native orientation.
`timescale 1ns/1ps
`default_nettype none
`include "arcade_shell_config.svh"

module control_mapper (
	input  wire                           clk_sys,
	input  wire                           rst_n,
	input  wire arcade_shell_pkg::shell_cfg_t cfg,
	output arcade_shell_pkg::player_ctrl_t player1,
	output arcade_shell_pkg::player_ctrl_t player2,
	output logic                          coin,
	output logic                          core_reset
);

	import arcade_shell_pkg::*;

	logic rotate;

	function automatic player_ctrl_t map_joy(input logic [7:0] joy, input logic rot);
		player_ctrl_t p;
		p.fire    = joy[joy_fire];
		p.barrier = joy[joy_barrier];
		p.start   = joy[joy_start];
		if (rot) begin
			// The stick turns a quarter with the monitor.
			p.up    = joy[joy_right];
			p.right = joy[joy_down];
			p.down  = joy[joy_left];
			p.left  = joy[joy_up];
		end else begin
			p.up    = joy[joy_up];
			p.right = joy[joy_right];
			p.down  = joy[joy_down];
			p.left  = joy[joy_left];
		end
		return p;
	endfunction

	assign rotate = cfg.status[2] ^ `ORIENT_ROT;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			player1    <= '0;
			player2    <= '0;
			coin       <= 1'b0;
			core_reset <= 1'b0;
		end else begin
			player1    <= map_joy(cfg.joy0, rotate);
			player2    <= map_joy(cfg.joy1, rotate);
			coin       <= cfg.joy0[joy_coin] | cfg.joy1[joy_coin];
			// Menu reset or the board's second button.
			core_reset <= cfg.status[0] | cfg.buttons[1];
		end
	end

endmodule

`default_nettype wire

// File: source/control_regs.sv
// AXI4-Lite register block; joystick registers keep 8 bits and buttons 4, the upper write bits are dropped.
`timescale 1ns/1ps
`default_nettype none
`include "arcade_shell_config.svh"

module control_regs (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire arcade_shell_pkg::axil_req_t axil_req,
	output arcade_shell_pkg::axil_rsp_t  axil_rsp,
	output arcade_shell_pkg::shell_cfg_t cfg
);

	import arcade_shell_pkg::*;

	logic [31:0] status_q;
	logic [7:0]  joy0_q;
	logic [7:0]  joy1_q;
	logic [3:0]  buttons_q;
	logic        wr_go;
	logic        rd_go;
	logic        wr_ok;
	logic        rd_ok;
	logic [31:0] old_word;
	logic [31:0] wr_word;
	logic [31:0] rd_word;
	logic        bvalid_q;
	logic [1:0]  bresp_q;
	logic        rvalid_q;
	logic [1:0]  rresp_q;
	logic [31:0] rdata_q;

	function automatic logic [31:0] merge_strb(
		input logic [31:0] cur,
		input logic [31:0] upd,
		input logic [3:0]  strb
	);
		logic [31:0] res;
		res = cur;
		for (int i = 0; i < 4; i++)
			if (strb[i])
				res[i*8 +: 8] = upd[i*8 +: 8];
		return res;
	endfunction

	// Both channels are taken in one cycle while no response is outstanding.
	assign wr_go = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
	assign rd_go = axil_req.arvalid & ~rvalid_q;

	always_comb begin
		wr_ok    = 1'b1;
		old_word = '0;
		case (axil_req.awaddr)
			reg_status:  old_word = status_q;
			reg_joy0:    old_word = {24'd0, joy0_q};
			reg_joy1:    old_word = {24'd0, joy1_q};
			reg_buttons: old_word = {28'd0, buttons_q};
			default:     wr_ok    = 1'b0;
		endcase
		wr_word = merge_strb(old_word, axil_req.wdata, axil_req.wstrb);
	end

	always_comb begin
		rd_ok   = 1'b1;
		rd_word = '0;
		case (axil_req.araddr)
			reg_status:  rd_word = status_q;
			reg_joy0:    rd_word = {24'd0, joy0_q};
			reg_joy1:    rd_word = {24'd0, joy1_q};
			reg_buttons: rd_word = {28'd0, buttons_q};
			reg_core_id: rd_word = `CORE_ID;
			default:     rd_ok   = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_q  <= '0;
			joy0_q    <= '0;
			joy1_q    <= '0;
			buttons_q <= '0;
			bvalid_q  <= 1'b0;
			rvalid_q  <= 1'b0;
		end else begin
			if (bvalid_q && axil_req.bready)
				bvalid_q <= 1'b0;
			if (rvalid_q && axil_req.rready)
				rvalid_q <= 1'b0;
			if (wr_go) begin
				bvalid_q <= 1'b1;
				case (axil_req.awaddr)
					reg_status:  status_q  <= wr_word;
					reg_joy0:    joy0_q    <= wr_word[7:0];
					reg_joy1:    joy1_q    <= wr_word[7:0];
					reg_buttons: buttons_q <= wr_word[3:0];
					default:     ;
				endcase
			end
			if (rd_go)
				rvalid_q <= 1'b1;
		end
	end

	// Unmapped reads already carry zero data from the mux above.
	always_ff @(posedge clk_sys) begin
		if (wr_go)
			bresp_q <= wr_ok ? axil_okay : axil_slverr;
		if (rd_go) begin
			rresp_q <= rd_ok ? axil_okay : axil_slverr;
			rdata_q <= rd_word;
		end
	end

	always_comb begin
		axil_rsp.awready = wr_go;
		axil_rsp.wready  = wr_go;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.arready = rd_go;
		axil_rsp.rvalid  = rvalid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
	end

	always_comb begin
		cfg.status  = status_q;
		cfg.joy0    = joy0_q;
		cfg.joy1    = joy1_q;
		cfg.buttons = buttons_q;
	end

endmodule

`default_nettype wire

// File: source/sigma_delta_dac.sv
// First-order sigma-delta DAC; the output needs an external RC low-pass and has no dither.
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac #(
	parameter int C_BITS = 12
) (
	input  wire              clk_sys,
	input  wire              rst_n,
	input  wire [C_BITS-1:0] dac_in,
	output logic             dac_out
);

	logic [C_BITS-1:0] acc_q;
	logic [C_BITS:0]   sum;

	// The carry out of the accumulator is the pulse density.
	assign sum = {1'b0, acc_q} + {1'b0, dac_in};

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc_q   <= '0;
			dac_out <= 1'b0;
		end else begin
			acc_q   <= sum[C_BITS-1:0];
			dac_out <= sum[C_BITS];
		end
	end

endmodule

`default_nettype wire

// File: source/spi_user_io.sv
// SPI mode 0 slave sampled in clk_sys; SCK must not exceed clk_sys/8 and only one bus access runs at a time.
`timescale 1ns/1ps
`default_nettype none
`include "arcade_shell_config.svh"

module spi_user_io (
	input  wire                         clk_sys,
	input  wire                         rst_n,
	input  wire                         spi_sck,
	input  wire                         spi_ss_io,
	input  wire                         spi_mosi,
	input  wire arcade_shell_pkg::axil_rsp_t axil_rsp,
	output wire                         spi_miso,
	output arcade_shell_pkg::axil_req_t axil_req
);

	logic [2:0]  sck_s;
	logic [1:0]  ss_s;
	logic [1:0]  mosi_s;
	logic        sel;
	logic        sck_rise;
	logic        sck_fall;
	logic [5:0]  bit_cnt;
	logic [31:0] rx_q;
	logic [7:0]  rx_byte;
	logic [7:0]  cmd_q;
	logic [7:0]  addr_q;
	logic [31:0] wdata_q;
	logic [31:0] tx_q;
	logic        rd_phase;
	logic        wr_issue;
	logic        rd_issue;
	logic        awvalid_q;
	logic        wvalid_q;
	logic        arvalid_q;

	// Two flops per line, plus a third on SCK for edge detection.
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			sck_s  <= '0;
			ss_s   <= '1;
			mosi_s <= '0;
		end else begin
			sck_s  <= {sck_s[1:0], spi_sck};
			ss_s   <= {ss_s[0], spi_ss_io};
			mosi_s <= {mosi_s[0], spi_mosi};
		end
	end

	assign sel      = ~ss_s[1];
	assign sck_rise = sel & sck_s[1] & ~sck_s[2];
	assign sck_fall = sel & ~sck_s[1] & sck_s[2];
	assign rx_byte  = {rx_q[6:0], mosi_s[1]};

	// Bit 7 closes the command byte, bit 15 the address, bit 47 the last write byte.
	assign rd_issue = sck_rise && bit_cnt == 6'd15 && cmd_q == `SPI_CMD_RD;
	assign wr_issue = sck_rise && bit_cnt == 6'd47 && cmd_q == `SPI_CMD_WR;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			bit_cnt  <= '0;
			cmd_q    <= '0;
			rd_phase <= 1'b0;
		end else if (!sel) begin
			bit_cnt  <= '0;
			rd_phase <= 1'b0;
		end else if (sck_rise && bit_cnt != 6'd48) begin
			bit_cnt <= bit_cnt + 6'd1;
			if (bit_cnt == 6'd7)
				cmd_q <= rx_byte;
			if (rd_issue)
				rd_phase <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sck_rise)
			rx_q <= {rx_q[30:0], mosi_s[1]};
		if (sck_rise && bit_cnt == 6'd15)
			addr_q <= rx_byte;
		if (wr_issue)
			wdata_q <= {rx_q[30:0], mosi_s[1]};
	end

	// Each valid drops on its own ready.
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			arvalid_q <= 1'b0;
		end else begin
			if (axil_rsp.awready)
				awvalid_q <= 1'b0;
			if (axil_rsp.wready)
				wvalid_q <= 1'b0;
			if (axil_rsp.arready)
				arvalid_q <= 1'b0;
			if (wr_issue) begin
				awvalid_q <= 1'b1;
				wvalid_q  <= 1'b1;
			end
			if (rd_issue)
				arvalid_q <= 1'b1;
		end
	end

	// Bit 31 is presented as soon as the read data lands.
	// The first falling edge after the address must not shift it away.
	always_ff @(posedge clk_sys) begin
		if (axil_rsp.rvalid)
			tx_q <= axil_rsp.rdata;
		else if (sck_fall && bit_cnt > 6'd16)
			tx_q <= {tx_q[30:0], 1'b0};
	end

	assign spi_miso = rd_phase & tx_q[31];

	always_comb begin
		axil_req         = '0;
		axil_req.awvalid = awvalid_q;
		axil_req.awaddr  = addr_q;
		axil_req.wvalid  = wvalid_q;
		axil_req.wdata   = wdata_q;
		axil_req.wstrb   = 4'hf;
		axil_req.bready  = 1'b1;
		axil_req.arvalid = arvalid_q;
		axil_req.araddr  = addr_q;
		axil_req.rready  = 1'b1;
	end

endmodule

`default_nettype wire

// File: test/tb_spi_tasks.svh
// SPI mode 0 master tasks, included inside the testbench module; SCK is clk_sys/10 with idle low.
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// Clock cycles per SCK half period.
localparam int half_sck = 5;

// Inputs always move 1 ns past a rising clock edge.
task automatic advance(input int n);
	repeat (n) @(posedge clk_sys);
	#1;
endtask

// MOSI changes with the falling SCK and MISO is taken just before the rise.
task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
	for (int i = 7; i >= 0; i--) begin
		spi_mosi = tx[i];
		advance(half_sck);
		rx[i] = spi_miso;
		spi_sck = 1'b1;
		advance(half_sck);
		spi_sck = 1'b0;
	end
endtask

task automatic open_frame();
	int n;
	n = 0;
	// The previous read must have released MISO.
	while (spi_miso !== 1'b0 && n < 50) begin
		advance(1);
		n++;
	end
	assert (n < 50) else
		fail_now("spi_miso did not return low between frames");
	spi_ss_io = 1'b0;
	advance(half_sck);
endtask

task automatic close_frame();
	advance(half_sck);
	spi_ss_io = 1'b1;
	advance(2 * half_sck);
endtask

task automatic write_frame(input logic [7:0] addr, input logic [31:0] data);
	logic [7:0] rx;
	open_frame();
	shift_byte(`SPI_CMD_WR, rx);
	shift_byte(addr, rx);
	for (int b = 3; b >= 0; b--)
		shift_byte(data[b*8 +: 8], rx);
	close_frame();
endtask

task automatic read_frame(input logic [7:0] addr, output logic [31:0] data);
	logic [7:0] rx;
	open_frame();
	shift_byte(`SPI_CMD_RD, rx);
	shift_byte(addr, rx);
	for (int b = 3; b >= 0; b--) begin
		shift_byte(8'h00, rx);
		data[b*8 +: 8] = rx;
	end
	close_frame();
endtask

// Select rises right after the address byte of a write.
task automatic abort_frame(input logic [7:0] addr);
	logic [7:0] rx;
	open_frame();
	shift_byte(`SPI_CMD_WR, rx);
	shift_byte(addr, rx);
	close_frame();
endtask

`endif

// File: test/tb_arcade_shell.sv
// Self-checking testbench for the shell; needs delay support, bit-bangs SPI at clk_sys/10 and stops at the first error.
`timescale 1ns/1ps
`default_nettype none
`include "arcade_shell_config.svh"

module tb_arcade_shell;

	import arcade_shell_pkg::*;

	logic                 clk_sys;
	logic                 rst_n;
	logic                 spi_sck;
	logic                 spi_ss_io;
	logic                 spi_mosi;
	logic [`DAC_BITS-1:0] audio_in;
	logic                 spi_miso;
	logic                 audio_out;
	logic                 core_reset;
	logic                 coin;
	player_ctrl_t         player1;
	player_ctrl_t         player2;
	logic [1:0]           scanlines;
	logic                 blend;
	logic [31:0]          rng;
	logic [31:0]          word;
	int                   ones;
	// Expected register contents.
	logic [31:0]          exp_status;
	logic [7:0]           exp_joy0;
	logic [7:0]           exp_joy1;
	logic [3:0]           exp_buttons;

	arcade_shell uut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.spi_sck    (spi_sck),
		.spi_ss_io  (spi_ss_io),
		.spi_mosi   (spi_mosi),
		.audio_in   (audio_in),
		.spi_miso   (spi_miso),
		.audio_out  (audio_out),
		.core_reset (core_reset),
		.coin       (coin),
		.player1    (player1),
		.player2    (player2),
		.scanlines  (scanlines),
		.blend      (blend)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		assert (got === want) else
			fail_now($sformatf("[FAIL] %0d ns %s got 0x%0h expected 0x%0h",
				$time, name, got, want));
	endtask

	`include "tb_spi_tasks.svh"

	// Joystick bits from 0 up are right, left, down, up, fire, barrier, start, coin.
	// A rotated cabinet turns the stick a quarter clockwise.
	function automatic player_ctrl_t expected_player(input logic [7:0] joy, input logic rot);
		player_ctrl_t p;
		if (rot)
			{p.up, p.right, p.down, p.left} = {joy[0], joy[2], joy[1], joy[3]};
		else
			{p.up, p.right, p.down, p.left} = {joy[3], joy[0], joy[2], joy[1]};
		{p.fire, p.barrier, p.start} = {joy[4], joy[5], joy[6]};
		return p;
	endfunction

	function automatic logic [31:0] model_word(input logic [7:0] addr);
		case (addr)
			reg_status:  return exp_status;
			reg_joy0:    return 32'(exp_joy0);
			reg_joy1:    return 32'(exp_joy1);
			reg_buttons: return 32'(exp_buttons);
			reg_core_id: return `CORE_ID;
			default:     return 32'd0;
		endcase
	endfunction

	// The identifier and unmapped addresses keep the model as it is.
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		write_frame(addr, data);
		case (addr)
			reg_status:  exp_status = data;
			reg_joy0:    exp_joy0 = data[7:0];
			reg_joy1:    exp_joy1 = data[7:0];
			reg_buttons: exp_buttons = data[3:0];
			default:     ;
		endcase
	endtask

	task automatic expect_read(input logic [7:0] addr);
		logic [31:0] got;
		read_frame(addr, got);
		check_value($sformatf("read data at 0x%02h", addr), got, model_word(addr));
	endtask

	// Polls until the decoded outputs match the model, then checks each one.
	task automatic wait_outputs();
		logic        rot;
		logic [18:0] want;
		int          n;
		rot = exp_status[2] ^ `ORIENT_ROT;
		want = {expected_player(exp_joy0, rot), expected_player(exp_joy1, rot),
			exp_joy0[7] | exp_joy1[7], exp_status[0] | exp_buttons[1],
			exp_status[4:3], exp_status[5]};
		n = 0;
		while (n < 50 && {player1, player2, coin, core_reset, scanlines, blend} !== want) begin
			advance(1);
			n++;
		end
		check_value("player1", {25'd0, player1}, 32'(want[18:12]));
		check_value("player2", {25'd0, player2}, 32'(want[11:5]));
		check_value("coin", 32'(coin), 32'(want[4]));
		check_value("core_reset", 32'(core_reset), 32'(want[3]));
		check_value("scanlines", 32'(scanlines), 32'(want[2:1]));
		check_value("blend", 32'(blend), 32'(want[0]));
	endtask

	initial begin
		rst_n = 1'b0;
		spi_sck = 1'b0;
		spi_ss_io = 1'b1;
		spi_mosi = 1'b0;
		audio_in = '0;
		rng = 32'h2e16_eed2;
		exp_status = '0;
		exp_joy0 = '0;
		exp_joy1 = '0;
		exp_buttons = '0;
		advance(8);
		rst_n = 1'b1;
		advance(2);

		check_value("core_reset", 32'(core_reset), 32'd0);
		check_value("coin", 32'(coin), 32'd0);
		check_value("player1", {25'd0, player1}, 32'd0);
		check_value("player2", {25'd0, player2}, 32'd0);
		check_value("scanlines", 32'(scanlines), 32'd0);
		check_value("blend", 32'(blend), 32'd0);
		check_value("audio_out", 32'(audio_out), 32'd0);
		check_value("spi_miso", 32'(spi_miso), 32'd0);
		expect_read(reg_status);

		// Random words into random writable registers, each one read back.
		for (int i = 0; i < 40; i++) begin
			rng = xorshift(rng);
			word = rng;
			rng = xorshift(rng);
			write_reg({4'd0, rng[1:0], 2'b00}, word);
			expect_read({4'd0, rng[1:0], 2'b00});
			wait_outputs();
		end

		for (int i = 0; i < 16; i++) begin
			rng = xorshift(rng);
			write_reg(reg_joy0, rng);
			write_reg(reg_joy1, {rng[7:0], rng[31:8]});
			rng = xorshift(rng);
			// Bit 2 picks the rotation, the rest stays small and random.
			write_reg(reg_status, 32'(rng[5:0]));
			wait_outputs();
		end

		for (int i = 0; i < 4; i++) begin
			write_reg(reg_status, 32'(i[0]));
			write_reg(reg_buttons, {30'd0, i[1], 1'b0});
			wait_outputs();
			check_value("core_reset", 32'(core_reset), 32'(i[0] | i[1]));
		end

		expect_read(reg_core_id);
		write_reg(reg_core_id, ~`CORE_ID);
		write_reg(8'h24, 32'hffff_ffff);
		abort_frame(reg_status);
		for (int a = 0; a < 5; a++)
			expect_read(8'(4 * a));
		expect_read(8'h24);

		// Over one full accumulator period the ones count equals the input.
		for (int i = 0; i < 3; i++) begin
			rng = xorshift(rng);
			audio_in = rng[`DAC_BITS-1:0];
			advance(16);
			ones = 0;
			for (int c = 0; c < (1 << `DAC_BITS); c++) begin
				advance(1);
				if (audio_out)
					ones++;
			end
			check_value("audio_out ones", ones, 32'(audio_in));
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
